// ==== src.f ====
+incdir+design
design/rs_div_pkg.sv
design/rs_dispatch.sv
design/rs_entry.sv
design/rs_issue_select.sv
design/rs_div.sv
testbench/tb_clock.sv
testbench/rs_div_asserts.sv
testbench/tb_rs_div.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_rs_div -f src.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi

exit 0

// ==== testbench/rs_div_stim.txt ====
# D pc rd op src1 src2 rdy1 rdy2 wport wtag (wport 7 = none), W port valid tag
# C sig(0 issue_valid, 1 disp_ready) value, P pc rd op src1 src2, I cycles, R mode, E expected, T end
R 0
D 00001000 10 0 20 21 1 1 7 00
C 0 1
E 00001000 10 0 20 21
T
D 00002000 11 1 30 31 0 0 7 00
W 0 0 30
W 0 1 30
C 0 0
W 0 1 31
D 00002004 12 2 32 33 0 0 7 00
W 1 0 32
W 1 1 32
C 0 0
W 1 1 33
D 00002008 13 3 34 35 0 0 7 00
W 2 0 34
W 2 1 34
W 2 1 35
D 0000200c 14 0 36 37 0 0 7 00
W 3 0 36
W 3 1 36
W 3 1 37
D 00002010 15 1 38 39 0 0 7 00
W 4 0 38
W 4 1 38
C 0 0
W 4 1 39
E 00002000 11 1 30 31
E 00002004 12 2 32 33
E 00002008 13 3 34 35
E 0000200c 14 0 36 37
E 00002010 15 1 38 39
T
D 00003000 16 2 40 41 0 1 3 40
E 00003000 16 2 40 41
T
D 00004000 17 0 50 51 0 1 7 00
D 00004004 18 1 50 51 0 1 7 00
D 00004008 19 2 50 51 0 1 7 00
W 1 1 50
E 00004000 17 0 50 51
E 00004004 18 1 50 51
E 00004008 19 2 50 51
T
D 00005000 20 0 60 61 0 1 7 00
D 00005004 21 1 60 61 0 1 7 00
D 00005008 22 2 60 61 0 1 7 00
D 0000500c 23 3 60 61 0 1 7 00
D 00005010 24 0 60 61 0 1 7 00
D 00005014 25 1 60 61 0 1 7 00
D 00005018 26 2 60 61 0 1 7 00
D 0000501c 27 3 60 61 0 1 7 00
C 1 0
D 00005020 28 0 62 63 1 1 4 60
E 00005000 20 0 60 61
E 00005004 21 1 60 61
E 00005008 22 2 60 61
E 0000500c 23 3 60 61
E 00005010 24 0 60 61
E 00005014 25 1 60 61
E 00005018 26 2 60 61
E 0000501c 27 3 60 61
E 00005020 28 0 62 63
T
R 1
D 00006000 30 0 70 71 0 1 7 00
D 00006004 31 1 72 73 1 1 7 00
P 00006004 31 1 72 73
W 2 1 70
P 00006004 31 1 72 73
R 0
I 3
R 2
D 00006008 32 2 74 75 1 1 7 00
D 0000600c 33 3 76 77 1 1 7 00
D 00006010 34 0 78 79 1 1 7 00
D 00006014 35 1 7a 7b 1 1 7 00
E 00006004 31 1 72 73
E 00006000 30 0 70 71
E 00006008 32 2 74 75
E 0000600c 33 3 76 77
E 00006010 34 0 78 79
E 00006014 35 1 7a 7b
T

// ==== testbench/tb_rs_div.sv ====
`default_nettype none

`include "rs_div_consts.svh"

module tb_rs_div;

    logic clk;
    logic reset;
    logic disp_valid;
    rs_div_pkg::rs_dispatch_t disp;
    logic disp_ready;
    rs_div_pkg::wakeup_bus_t wakeup;
    logic issue_valid;
    rs_div_pkg::rs_payload_t issue;
    logic issue_ready;

    string lines[$];
    rs_div_pkg::rs_payload_t exp_q[$];
    int mode;
    int lim;
    int cycles;
    int errors;
    int test_errors;
    int checks;
    int tests_run;

    tb_clock u_clock (.clk(clk));

    rs_div UUT (
        .clk(clk),
        .reset(reset),
        .disp_valid(disp_valid),
        .disp(disp),
        .disp_ready(disp_ready),
        .wakeup(wakeup),
        .issue_valid(issue_valid),
        .issue(issue),
        .issue_ready(issue_ready)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic compare_payload(input rs_div_pkg::rs_payload_t got,
                                   input rs_div_pkg::rs_payload_t exp);
        check_value("issue.pc", got.pc, exp.pc);
        check_value("issue.rd", 32'(got.rd), 32'(exp.rd));
        check_value("issue.op", 32'(got.op), 32'(exp.op));
        check_value("issue.src1", 32'(got.src1), 32'(exp.src1));
        check_value("issue.src2", 32'(got.src2), 32'(exp.src2));
    endtask

    // Advance to just after the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        case (mode)
            0: issue_ready = 1'b1;
            1: issue_ready = 1'b0;
            default: issue_ready = 1'($urandom % 2);
        endcase
    endtask

    function automatic rs_div_pkg::rs_payload_t make_payload(input logic [31:0] pc,
            input logic [31:0] rd, input logic [31:0] op,
            input logic [31:0] s1, input logic [31:0] s2);
        rs_div_pkg::rs_payload_t p;
        p.pc = pc;
        p.rd = rd[7:0];
        p.op = rs_div_pkg::div_op_e'(op[3:0]);
        p.src1 = s1[7:0];
        p.src2 = s2[7:0];
        return p;
    endfunction

    task automatic dispatch_one(input rs_div_pkg::rs_dispatch_t d, input int wp,
                                input logic [7:0] wt);
        disp = d;
        disp_valid = 1'b1;
        if (wp < `RS_WAKE_PORTS) begin
            wakeup[wp].valid = 1'b1; // Same-cycle broadcast
            wakeup[wp].tag = wt;
        end
        @(negedge clk);
        while (!disp_ready) begin
            next_cycle();
            wakeup = '0;
            @(negedge clk);
        end
        next_cycle();
        disp_valid = 1'b0;
        wakeup = '0;
    endtask

    task automatic run_record(input string line);
        logic [31:0] f [9];
        rs_div_pkg::rs_dispatch_t d;
        int n;
        n = 0;
        case (line.getc(0))
            "D": begin
                n = $sscanf(line, "D %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                            f[3], f[4], f[5], f[6], f[7], f[8]);
                d.payload = make_payload(f[0], f[1], f[2], f[3], f[4]);
                d.src1_ready = f[5][0];
                d.src2_ready = f[6][0];
                dispatch_one(d, int'(f[7]), f[8][7:0]);
            end
            "W": begin
                n = $sscanf(line, "W %h %h %h", f[0], f[1], f[2]);
                wakeup[int'(f[0])].valid = f[1][0];
                wakeup[int'(f[0])].tag = f[2][7:0];
                next_cycle();
                wakeup = '0;
            end
            "C": begin
                n = $sscanf(line, "C %h %h", f[0], f[1]);
                @(negedge clk);
                if (f[0] == 0) begin
                    check_value("issue_valid", 32'(issue_valid), f[1]);
                end else begin
                    check_value("disp_ready", 32'(disp_ready), f[1]);
                end
                next_cycle();
            end
            "P": begin
                n = $sscanf(line, "P %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                @(negedge clk);
                check_value("issue_valid", 32'(issue_valid), 32'd1);
                compare_payload(issue, make_payload(f[0], f[1], f[2], f[3], f[4]));
                next_cycle();
            end
            "I": begin
                n = $sscanf(line, "I %h", f[0]);
                repeat (int'(f[0])) next_cycle();
            end
            "R": begin
                n = $sscanf(line, "R %h", f[0]);
                mode = int'(f[0]);
            end
            default: begin
            end
        endcase
    endtask

    task automatic run_tests();
        logic [31:0] f [5];
        int idx;
        int last;
        int n;
        idx = 0;
        while (idx < lines.size()) begin
            last = idx;
            while (last < lines.size() - 1 && lines[last].getc(0) != "T") begin
                last++;
            end
            for (int k = idx; k <= last; k++) begin
                if (lines[k].getc(0) == "E") begin // Expected issues first
                    n = $sscanf(lines[k], "E %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                    exp_q.push_back(make_payload(f[0], f[1], f[2], f[3], f[4]));
                end
            end
            for (int k = idx; k <= last; k++) begin
                run_record(lines[k]);
            end
            while (exp_q.size() > 0) begin
                next_cycle();
            end
            repeat (4) next_cycle(); // Catch stray issues
            tests_run++;
            if (test_errors == 0) begin
                $display("test %0d ok", tests_run);
            end else begin
                $display("test %0d: %0d errors", tests_run, test_errors);
            end
            test_errors = 0;
            idx = last + 1;
        end
    endtask

    // Scoreboard pops one expected issue per transfer at the next rising edge
    always @(negedge clk) begin : monitor
        rs_div_pkg::rs_payload_t e;
        if (!reset && issue_valid && issue_ready) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected issue of pc %h", issue.pc);
                errors++;
                test_errors++;
            end else begin
                e = exp_q.pop_front();
                compare_payload(issue, e);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (lim > 0 && cycles > lim) begin
            $display("Run exceeded %0d cycles without finishing", lim);
            $display("Test failed");
            $finish;
        end
    end

    initial begin : main
        int fd;
        int n;
        int seed;
        string line;
        reset = 1'b1;
        disp_valid = 1'b0;
        disp = '0;
        wakeup = '0;
        issue_ready = 1'b0;
        mode = 0;
        lim = 0;
        cycles = 0;
        errors = 0;
        test_errors = 0;
        checks = 0;
        tests_run = 0;
        seed = $urandom(32'ha502af3d);
        fd = $fopen("testbench/rs_div_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            $display("Test failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
            lim = lines.size() * 40 + 200;
            repeat (8) @(posedge clk);
            #1;
            reset = 1'b0;
            run_tests();
            $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
            if (errors == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/rs_div_asserts.sv ====
`default_nettype none

`include "rs_div_consts.svh"

module rs_div_asserts (
    input wire clk,
    input wire reset,
    input wire disp_ready,
    input wire issue_valid,
    input wire issue_ready,
    input wire rs_div_pkg::rs_payload_t issue,
    input wire [$clog2(`RS_ENTRIES):0] in_flight
);

    // Presented payload holds under back-pressure
    issue_stable: assert property (@(posedge clk) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue))
        else $error("issue changed while stalled");

    full_only: assert property (@(posedge clk) disable iff (reset)
        !disp_ready |-> in_flight == `RS_ENTRIES)
        else $error("disp_ready low with free entries");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !issue_valid)
        else $error("issue_valid high right after reset");

endmodule

bind rs_div rs_div_asserts u_asserts (
    .clk(clk),
    .reset(reset),
    .disp_ready(disp_ready),
    .issue_valid(issue_valid),
    .issue_ready(issue_ready),
    .issue(issue),
    .in_flight(u_dispatch.in_flight)
);

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk; // Period 40

endmodule

`default_nettype wire

// ==== design/rs_div.sv ====
`default_nettype none

`include "rs_div_consts.svh"

module rs_div (
    input wire clk,
    input wire reset,
    input wire disp_valid,
    input wire rs_div_pkg::rs_dispatch_t disp,
    output logic disp_ready,
    input wire rs_div_pkg::wakeup_bus_t wakeup,
    output logic issue_valid,
    output rs_div_pkg::rs_payload_t issue,
    input wire issue_ready
);

    logic [`RS_ENTRIES-1:0] alloc;
    logic [`RS_ENTRIES-1:0] occupied;
    logic [`RS_ENTRIES-1:0] req;
    logic [`RS_ENTRIES-1:0] release_en;
    rs_div_pkg::rs_dispatch_t alloc_data; // Shared by all entries
    rs_div_pkg::rs_payload_t payloads [`RS_ENTRIES];

    rs_dispatch u_dispatch (
        .clk(clk),
        .reset(reset),
        .disp_valid(disp_valid),
        .disp(disp),
        .disp_ready(disp_ready),
        .wakeup(wakeup),
        .occupied(occupied),
        .alloc(alloc),
        .alloc_data(alloc_data)
    );

    for (genvar i = 0; i < `RS_ENTRIES; i++) begin : g_entry
        rs_entry u_entry (
            .clk(clk),
            .reset(reset),
            .alloc(alloc[i]),
            .alloc_data(alloc_data),
            .wakeup(wakeup),
            .release_en(release_en[i]),
            .occupied(occupied[i]),
            .req(req[i]),
            .payload(payloads[i])
        );
    end

    rs_issue_select u_select (
        .clk(clk),
        .reset(reset),
        .alloc(alloc),
        .req(req),
        .payloads(payloads),
        .issue_valid(issue_valid),
        .issue(issue),
        .issue_ready(issue_ready),
        .release_en(release_en)
    );

endmodule

`default_nettype wire

// ==== design/rs_issue_select.sv ====
`default_nettype none

`include "rs_div_consts.svh"

module rs_issue_select (
    input wire clk,
    input wire reset,
    input wire [`RS_ENTRIES-1:0] alloc,
    input wire [`RS_ENTRIES-1:0] req,
    input wire rs_div_pkg::rs_payload_t payloads [`RS_ENTRIES],
    output logic issue_valid,
    output rs_div_pkg::rs_payload_t issue,
    input wire issue_ready,
    output logic [`RS_ENTRIES-1:0] release_en
);

    localparam int IDX_W = $clog2(`RS_ENTRIES);

    // older_than[i][j] set when entry j is older than entry i
    logic [`RS_ENTRIES-1:0] older_than [`RS_ENTRIES];
    logic [`RS_ENTRIES-1:0] oldest;
    logic [IDX_W-1:0] oldest_idx;
    logic [IDX_W-1:0] lock_idx;
    logic [IDX_W-1:0] sel_idx;
    logic holding;
    logic transfer;
    rs_div_pkg::sel_state_e state;

    // New entry is younger than every other slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (reset) begin
                older_than[i] <= '0;
            end else if (alloc[i]) begin
                older_than[i] <= ~alloc;
            end else begin
                older_than[i] <= older_than[i] & ~alloc;
            end
        end
    end

    // Requester with no older requester
    always_comb begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            oldest[i] = req[i] && !(|(older_than[i] & req));
        end
    end

    always_comb begin
        oldest_idx = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (oldest[i]) begin
                oldest_idx = IDX_W'(i);
            end
        end
    end

    assign holding = (state == rs_div_pkg::SEL_HOLD);
    assign sel_idx = holding ? lock_idx : oldest_idx;
    assign issue_valid = holding || (|oldest);
    assign issue = payloads[sel_idx];
    assign transfer = issue_valid && issue_ready;

    always_comb begin
        release_en = '0;
        if (transfer) begin
            release_en[sel_idx] = 1'b1;
        end
    end

    // Lock the presented entry under back-pressure
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rs_div_pkg::SEL_IDLE;
            lock_idx <= '0;
        end else begin
            case (state)
                rs_div_pkg::SEL_IDLE: begin
                    if (issue_valid && !issue_ready) begin
                        state <= rs_div_pkg::SEL_HOLD;
                        lock_idx <= oldest_idx;
                    end
                end
                rs_div_pkg::SEL_HOLD: begin
                    if (issue_ready) begin
                        state <= rs_div_pkg::SEL_IDLE; // Entry freed on acceptance
                    end
                end
                default: begin
                    state <= rs_div_pkg::SEL_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/rs_entry.sv ====
`default_nettype none

`include "rs_div_consts.svh"

module rs_entry (
    input wire clk,
    input wire reset,
    input wire alloc,
    input wire rs_div_pkg::rs_dispatch_t alloc_data,
    input wire rs_div_pkg::wakeup_bus_t wakeup,
    input wire release_en,
    output logic occupied,
    output logic req,
    output rs_div_pkg::rs_payload_t payload
);

    logic src1_ready;
    logic src2_ready;
    logic src1_hit;
    logic src2_hit;

    assign src1_hit = rs_div_pkg::wakeup_hit(wakeup, payload.src1);
    assign src2_hit = rs_div_pkg::wakeup_hit(wakeup, payload.src2);

    always_ff @(posedge clk) begin
        if (reset) begin
            occupied <= 1'b0;
            src1_ready <= 1'b0;
            src2_ready <= 1'b0;
        end else if (alloc) begin
            occupied <= 1'b1;
            src1_ready <= alloc_data.src1_ready; // Already bypassed
            src2_ready <= alloc_data.src2_ready;
        end else begin
            if (release_en) begin
                occupied <= 1'b0;
            end
            if (occupied && !src1_ready && src1_hit) begin
                src1_ready <= 1'b1;
            end
            if (occupied && !src2_ready && src2_hit) begin
                src2_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            payload <= alloc_data.payload;
        end
    end

    assign req = occupied && src1_ready && src2_ready;

endmodule

`default_nettype wire

// ==== design/rs_dispatch.sv ====
`default_nettype none

`include "rs_div_consts.svh"

module rs_dispatch (
    input wire clk,
    input wire reset,
    input wire disp_valid,
    input wire rs_div_pkg::rs_dispatch_t disp,
    output logic disp_ready,
    input wire rs_div_pkg::wakeup_bus_t wakeup,
    input wire [`RS_ENTRIES-1:0] occupied,
    output logic [`RS_ENTRIES-1:0] alloc,
    output rs_div_pkg::rs_dispatch_t alloc_data
);

    localparam int CNT_W = $clog2(`RS_ENTRIES) + 1;

    logic [`RS_ENTRIES-1:0] free_pick;
    logic [`RS_ENTRIES-1:0] occ_q;
    logic [CNT_W-1:0] in_flight;
    logic accept;
    logic retire;

    // Lowest-index empty entry wins
    always_comb begin
        free_pick = '0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                free_pick = '0;
                free_pick[i] = 1'b1;
            end
        end
    end

    assign disp_ready = ~&occupied;
    assign accept = disp_valid && disp_ready;
    assign alloc = accept ? free_pick : '0;

    // Same-cycle wakeup bypass
    always_comb begin
        alloc_data = disp;
        alloc_data.src1_ready = disp.src1_ready
                              | rs_div_pkg::wakeup_hit(wakeup, disp.payload.src1);
        alloc_data.src2_ready = disp.src2_ready
                              | rs_div_pkg::wakeup_hit(wakeup, disp.payload.src2);
    end

    // An entry that drops occupied has been issued
    assign retire = |(occ_q & ~occupied);

    always_ff @(posedge clk) begin
        if (reset) begin
            occ_q <= '0;
            in_flight <= '0;
        end else begin
            occ_q <= occupied;
            in_flight <= in_flight + CNT_W'(accept) - CNT_W'(retire); // Accepted minus issued
        end
    end

endmodule

`default_nettype wire

// ==== design/rs_div_pkg.sv ====
`default_nettype none

`include "rs_div_consts.svh"

package rs_div_pkg;

    typedef enum logic [`RS_OP_W-1:0] {
        DIV,
        DIVU,
        REM,
        REMU
    } div_op_e;

    // Issue lock FSM
    typedef enum logic {
        SEL_IDLE,
        SEL_HOLD
    } sel_state_e;

    typedef struct packed {
        logic [`RS_PC_W-1:0] pc;
        logic [`RS_TAG_W-1:0] rd;
        div_op_e op;
        logic [`RS_TAG_W-1:0] src1;
        logic [`RS_TAG_W-1:0] src2;
    } rs_payload_t;

    typedef struct packed {
        rs_payload_t payload;
        logic src1_ready;
        logic src2_ready;
    } rs_dispatch_t;

    typedef struct packed {
        logic valid;
        logic [`RS_TAG_W-1:0] tag;
    } wakeup_t;

    // Ports in order ALU, MUL, DIV, load, branch
    typedef wakeup_t [`RS_WAKE_PORTS-1:0] wakeup_bus_t;

    // True when any valid broadcast carries this tag
    function automatic logic wakeup_hit(input wakeup_bus_t bus,
                                        input logic [`RS_TAG_W-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `RS_WAKE_PORTS; p++) begin
            if (bus[p].valid && bus[p].tag == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

endpackage

`default_nettype wire

// ==== design/rs_div_consts.svh ====
`ifndef RS_DIV_CONSTS_SVH
`define RS_DIV_CONSTS_SVH

// Station geometry
`define RS_ENTRIES 8
`define RS_WAKE_PORTS 5

// Field widths
`define RS_TAG_W 8
`define RS_PC_W 32
`define RS_OP_W 4

`endif
